/* fast_pkg.sv */
`default_nettype none

package fast_pkg;

    // frame geometry
    localparam int FRAME_W     = 16;
    localparam int FRAME_H     = 12;
    localparam int COORD_BITS  = 4;
    localparam int PIX_BITS    = 8;
    localparam int FRAME_BEATS = FRAME_W * FRAME_H;

    // window and segment test
    localparam int WIN_SIZE       = 7;
    localparam int RADIUS         = 3;
    localparam int CIRCLE_LEN     = 16;
    localparam int EDGE           = 3;
    localparam int FAST_THRESHOLD = 20;
    localparam int ARC_LEN        = 9;
    localparam int SCORE_BITS     = 8;

    // beats from the start pixel until the (0,0) result is ready
    localparam int FILL_BEATS    = RADIUS * FRAME_W + RADIUS + 1 + 2;
    localparam int FILL_CNT_BITS = $clog2(FILL_BEATS + 1);

    typedef logic [PIX_BITS-1:0]   pixel_t;
    typedef logic [COORD_BITS-1:0] coord_t;

    // circle[0] is the top pixel, then clockwise
    typedef struct packed {
        pixel_t [CIRCLE_LEN-1:0] circle;
        pixel_t                  centre;
    } fast_win_t;

    typedef struct packed {
        logic                  flag;
        logic [SCORE_BITS-1:0] score;
    } corner_t;

    typedef struct packed {
        coord_t                x;
        coord_t                y;
        logic                  flag;
        logic [SCORE_BITS-1:0] score;
    } keypoint_t;

endpackage

`default_nettype wire

/* line_window.sv */
`timescale 1ns/1ps
`default_nettype none

module line_window (
    input  wire                 i_clk,
    input  wire                 i_rst_n,
    input  wire                 i_valid,
    input  wire fast_pkg::pixel_t i_pixel,
    output fast_pkg::fast_win_t o_win
);
    import fast_pkg::*;

    // line_mem[WIN_SIZE-2] is one row up, line_mem[0] is six rows up
    pixel_t    line_mem [0:WIN_SIZE-2][0:FRAME_W-1];
    pixel_t    col_in   [0:WIN_SIZE-1];
    pixel_t    win_q    [0:WIN_SIZE-1][1:WIN_SIZE-1];
    pixel_t    view     [0:WIN_SIZE-1][0:WIN_SIZE-1];
    coord_t    col_q;
    fast_win_t taps;

    // newest column enters at view column 0
    always_comb begin
        for (int r = 0; r < WIN_SIZE - 1; r++) begin
            col_in[r] = line_mem[r][col_q];
        end
        col_in[WIN_SIZE-1] = i_pixel;
        for (int r = 0; r < WIN_SIZE; r++) begin
            view[r][0] = col_in[r];
            for (int c = 1; c < WIN_SIZE; c++) begin
                view[r][c] = win_q[r][c];
            end
        end
    end

    // image x grows as view column drops
    always_comb begin
        taps.circle[0]  = view[0][3];
        taps.circle[1]  = view[0][2];
        taps.circle[2]  = view[1][1];
        taps.circle[3]  = view[2][0];
        taps.circle[4]  = view[3][0];
        taps.circle[5]  = view[4][0];
        taps.circle[6]  = view[5][1];
        taps.circle[7]  = view[6][2];
        taps.circle[8]  = view[6][3];
        taps.circle[9]  = view[6][4];
        taps.circle[10] = view[5][5];
        taps.circle[11] = view[4][6];
        taps.circle[12] = view[3][6];
        taps.circle[13] = view[2][6];
        taps.circle[14] = view[1][5];
        taps.circle[15] = view[0][4];
        taps.centre     = view[RADIUS][RADIUS];
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            col_q <= '0;
        end else if (i_valid) begin
            col_q <= (col_q == coord_t'(FRAME_W - 1)) ? '0 : col_q + 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            // each line passes its old pixel up to the line above
            line_mem[WIN_SIZE-2][col_q] <= i_pixel;
            for (int r = 0; r < WIN_SIZE - 2; r++) begin
                line_mem[r][col_q] <= line_mem[r+1][col_q];
            end
            for (int r = 0; r < WIN_SIZE; r++) begin
                win_q[r][1] <= col_in[r];
                for (int c = 2; c < WIN_SIZE; c++) begin
                    win_q[r][c] <= win_q[r][c-1];
                end
            end
            o_win <= taps;
        end
    end

endmodule

`default_nettype wire

/* frame_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_sequencer (
    input  wire              i_clk,
    input  wire              i_rst_n,
    input  wire              i_valid,
    input  wire              i_start,
    output logic             o_ready,
    output logic             o_start,
    output logic             o_end,
    output logic             o_point,
    output fast_pkg::coord_t o_x,
    output fast_pkg::coord_t o_y
);
    import fast_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_FILL,
        S_WORK
    } state_t;

    state_t                   state_q;
    logic [FILL_CNT_BITS-1:0] beat_q;
    coord_t                   x_q;
    coord_t                   y_q;
    logic                     start_q;
    logic                     end_q;
    logic                     first_pt;
    logic                     last_pt;
    logic                     row_end;

    assign row_end  = (x_q == coord_t'(FRAME_W - 1));
    assign first_pt = (x_q == '0) && (y_q == '0);
    assign last_pt  = row_end && (y_q == coord_t'(FRAME_H - 1));

    assign o_point = (state_q == S_WORK) && i_valid;
    assign o_ready = (state_q == S_IDLE);
    // strobes line up with the registered keypoint
    assign o_start = start_q;
    assign o_end   = end_q;
    assign o_x     = x_q;
    assign o_y     = y_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= S_IDLE;
            beat_q  <= '0;
            x_q     <= '0;
            y_q     <= '0;
            start_q <= 1'b0;
            end_q   <= 1'b0;
        end else begin
            start_q <= o_point && first_pt;
            end_q   <= o_point && last_pt;
            if (i_valid) begin
                case (state_q)
                    S_IDLE: begin
                        if (i_start) begin
                            state_q <= S_FILL;
                            beat_q  <= FILL_CNT_BITS'(1);
                        end
                    end
                    S_FILL: begin
                        beat_q <= beat_q + 1'b1;
                        if (beat_q == FILL_CNT_BITS'(FILL_BEATS - 1)) begin
                            state_q <= S_WORK;
                            x_q     <= '0;
                            y_q     <= '0;
                        end
                    end
                    S_WORK: begin
                        if (last_pt) begin
                            state_q <= S_IDLE;
                            x_q     <= '0;
                            y_q     <= '0;
                        end else if (row_end) begin
                            x_q <= '0;
                            y_q <= y_q + 1'b1;
                        end else begin
                            x_q <= x_q + 1'b1;
                        end
                    end
                    default: state_q <= S_IDLE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* fast9_segment_test.sv */
`timescale 1ns/1ps
`default_nettype none

module fast9_segment_test (
    input  wire                    i_clk,
    input  wire                    i_rst_n,
    input  wire                    i_valid,
    input  wire fast_pkg::fast_win_t i_win,
    output fast_pkg::corner_t      o_corner
);
    import fast_pkg::*;

    logic [CIRCLE_LEN-1:0]   bright_d;
    logic [CIRCLE_LEN-1:0]   dark_d;
    logic [CIRCLE_LEN-1:0]   bright_q;
    logic [CIRCLE_LEN-1:0]   dark_q;
    pixel_t [CIRCLE_LEN-1:0] excess_d;
    pixel_t [CIRCLE_LEN-1:0] excess_q;
    logic [PIX_BITS:0]       hi_sum;
    pixel_t                  hi_lim;
    pixel_t                  lo_lim;
    logic [SCORE_BITS+3:0]   sum;
    corner_t                 corner_d;

    // true when the ring holds ARC_LEN contiguous ones
    function automatic logic has_arc(input logic [CIRCLE_LEN-1:0] mask);
        logic [2*CIRCLE_LEN-1:0] ring;
        logic                    found;
        ring  = {mask, mask};
        found = 1'b0;
        for (int s = 0; s < CIRCLE_LEN; s++) begin
            if (&ring[s +: ARC_LEN]) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    // stage 1 limits, both clamped to the pixel range
    always_comb begin
        hi_sum = {1'b0, i_win.centre} + {1'b0, pixel_t'(FAST_THRESHOLD)};
        hi_lim = hi_sum[PIX_BITS] ? '1 : hi_sum[PIX_BITS-1:0];
        if (i_win.centre < pixel_t'(FAST_THRESHOLD)) begin
            lo_lim = '0;
        end else begin
            lo_lim = i_win.centre - pixel_t'(FAST_THRESHOLD);
        end
        for (int i = 0; i < CIRCLE_LEN; i++) begin
            bright_d[i] = i_win.circle[i] > hi_lim;
            dark_d[i]   = i_win.circle[i] < lo_lim;
            if (bright_d[i]) begin
                excess_d[i] = i_win.circle[i] - hi_lim;
            end else if (dark_d[i]) begin
                excess_d[i] = lo_lim - i_win.circle[i];
            end else begin
                excess_d[i] = '0;
            end
        end
    end

    // stage 2
    always_comb begin
        sum = '0;
        for (int i = 0; i < CIRCLE_LEN; i++) begin
            sum = sum + (SCORE_BITS+4)'(excess_q[i]);
        end
        corner_d.flag = has_arc(bright_q) || has_arc(dark_q);
        if (!corner_d.flag) begin
            corner_d.score = '0;
        end else if (|sum[SCORE_BITS+3:SCORE_BITS]) begin
            corner_d.score = '1;
        end else begin
            corner_d.score = sum[SCORE_BITS-1:0];
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bright_q <= '0;
            dark_q   <= '0;
            o_corner <= '0;
        end else if (i_valid) begin
            bright_q <= bright_d;
            dark_q   <= dark_d;
            o_corner <= corner_d;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            excess_q <= excess_d;
        end
    end

endmodule

`default_nettype wire

/* keypoint_output.sv */
`timescale 1ns/1ps
`default_nettype none

module keypoint_output (
    input  wire                  i_clk,
    input  wire                  i_rst_n,
    input  wire                  i_point,
    input  wire fast_pkg::coord_t  i_x,
    input  wire fast_pkg::coord_t  i_y,
    input  wire fast_pkg::corner_t i_corner,
    output fast_pkg::keypoint_t  o_keypoint,
    output logic                 o_point_valid
);
    import fast_pkg::*;

    logic      in_margin;
    keypoint_t rec;

    // window reaches past the frame edge here
    always_comb begin
        in_margin = (i_x < coord_t'(EDGE))
                 || (i_x > coord_t'(FRAME_W - 1 - EDGE))
                 || (i_y < coord_t'(EDGE))
                 || (i_y > coord_t'(FRAME_H - 1 - EDGE));
        rec.x     = i_x;
        rec.y     = i_y;
        rec.flag  = in_margin ? 1'b0 : i_corner.flag;
        rec.score = in_margin ? '0 : i_corner.score;
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_point_valid <= 1'b0;
            o_keypoint    <= '0;
        end else begin
            o_point_valid <= i_point;
            if (i_point) begin
                o_keypoint <= rec;
            end
        end
    end

endmodule

`default_nettype wire

/* fast_detector_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fast_detector_top (
    input  wire                   i_clk,
    input  wire                   i_rst_n,
    input  wire fast_pkg::pixel_t i_pixel,
    input  wire                   i_valid,
    input  wire                   i_start,
    output logic                  o_ready,
    output logic                  o_start,
    output logic                  o_end,
    output logic                  o_point_valid,
    output fast_pkg::keypoint_t   o_keypoint
);
    import fast_pkg::*;

    fast_win_t win;
    corner_t   corner;
    coord_t    pt_x;
    coord_t    pt_y;
    logic      point;

    line_window u_line_window (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (i_valid),
        .i_pixel (i_pixel),
        .o_win   (win)
    );

    frame_sequencer u_frame_sequencer (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (i_valid),
        .i_start (i_start),
        .o_ready (o_ready),
        .o_start (o_start),
        .o_end   (o_end),
        .o_point (point),
        .o_x     (pt_x),
        .o_y     (pt_y)
    );

    fast9_segment_test u_segment_test (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_valid  (i_valid),
        .i_win    (win),
        .o_corner (corner)
    );

    keypoint_output u_keypoint_output (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_point       (point),
        .i_x           (pt_x),
        .i_y           (pt_y),
        .i_corner      (corner),
        .o_keypoint    (o_keypoint),
        .o_point_valid (o_point_valid)
    );

endmodule

`default_nettype wire

/* tb_fast_detector.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fast_detector;
    import fast_pkg::*;

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 16;
    localparam int GAP_LEN       = 16;
    localparam int CORNER_SLOTS  = 8;
    localparam int GAP_BASE      = FRAME_BEATS;
    localparam int COUNT_BASE    = GAP_BASE + GAP_LEN;
    localparam int LIST_BASE     = COUNT_BASE + 1;
    localparam int STIM_WORDS    = LIST_BASE + 3 * CORNER_SLOTS;
    localparam int READY_TIMEOUT = 100;
    localparam int FRAME_TIMEOUT = 2000;

    logic      i_clk;
    logic      i_rst_n;
    logic      i_valid;
    logic      i_start;
    pixel_t    i_pixel;
    logic      o_ready;
    logic      o_start;
    logic      o_end;
    logic      o_point_valid;
    keypoint_t o_keypoint;

    logic [7:0] stim      [0:STIM_WORDS-1];
    logic       exp_flag  [0:FRAME_BEATS-1];
    logic [7:0] exp_score [0:FRAME_BEATS-1];

    fast_detector_top UUT (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_pixel       (i_pixel),
        .i_valid       (i_valid),
        .i_start       (i_start),
        .o_ready       (o_ready),
        .o_start       (o_start),
        .o_end         (o_end),
        .o_point_valid (o_point_valid),
        .o_keypoint    (o_keypoint)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("Errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1, "run stopped");
    endtask

    function automatic logic in_margin(input int x, input int y);
        return (x < EDGE) || (x > FRAME_W - 1 - EDGE) || (y < EDGE) || (y > FRAME_H - 1 - EDGE);
    endfunction

    // image, gap flags and corner list all come from one file
    task automatic load_expected();
        int count;
        int x;
        int y;
        $readmemh("fast_stimulus.txt", stim);
        for (int i = 0; i < FRAME_BEATS; i++) begin
            exp_flag[i]  = 1'b0;
            exp_score[i] = 8'h00;
        end
        count = int'(stim[COUNT_BASE]);
        if (count > CORNER_SLOTS) begin
            report_failure("stimulus file lists more corners than it has room for");
        end
        for (int i = 0; i < count; i++) begin
            x = int'(stim[LIST_BASE + 3 * i]);
            y = int'(stim[LIST_BASE + 3 * i + 1]);
            if (x >= FRAME_W || y >= FRAME_H) begin
                report_failure("stimulus file has a corner outside the frame");
            end
            exp_flag[y * FRAME_W + x]  = 1'b1;
            exp_score[y * FRAME_W + x] = stim[LIST_BASE + 3 * i + 2];
        end
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge i_clk);
            check_value("o_ready", 32'(o_ready), 32'd1);
            check_value("o_point_valid", 32'(o_point_valid), 32'd0);
            check_value("o_start", 32'(o_start), 32'd0);
            check_value("o_end", 32'(o_end), 32'd0);
        end
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (o_ready !== 1'b1) begin
            @(negedge i_clk);
            n++;
            if (n > READY_TIMEOUT) begin
                report_failure("o_ready did not come back high in time");
            end
        end
    endtask

    // feeds one frame plus flush pixels and checks every point
    task automatic run_frame(input bit use_gaps);
        int         fed;
        int         cyc;
        int         points;
        int         ex;
        int         ey;
        bit         stall;
        bit         prev_valid;
        bit         done;
        logic       want_flag;
        logic [7:0] want_score;
        wait_ready();
        fed    = 0;
        cyc    = 0;
        points = 0;
        done   = 1'b0;
        while (!done) begin
            stall   = use_gaps && (fed > 0) && (stim[GAP_BASE + cyc % GAP_LEN] != 8'h00);
            i_valid = !stall;
            i_start = (fed == 0);
            i_pixel = (fed < FRAME_BEATS) ? stim[fed] : 8'h00;
            if (!stall) begin
                fed++;
            end
            prev_valid = !stall;
            cyc++;
            @(negedge i_clk);
            if (o_point_valid === 1'b1) begin
                if (!prev_valid) begin
                    report_failure("o_point_valid appeared on a stalled cycle");
                end
                ex = points % FRAME_W;
                ey = points / FRAME_W;
                if (in_margin(ex, ey)) begin
                    want_flag  = 1'b0;
                    want_score = 8'h00;
                end else begin
                    want_flag  = exp_flag[points];
                    want_score = exp_score[points];
                end
                check_value("o_keypoint.x", 32'(o_keypoint.x), 32'(ex));
                check_value("o_keypoint.y", 32'(o_keypoint.y), 32'(ey));
                check_value("o_keypoint.flag", 32'(o_keypoint.flag), 32'(want_flag));
                check_value("o_keypoint.score", 32'(o_keypoint.score), 32'(want_score));
                check_value("o_start", 32'(o_start), 32'(points == 0));
                check_value("o_end", 32'(o_end), 32'(points == FRAME_BEATS - 1));
                points++;
                if (points == FRAME_BEATS) begin
                    done = 1'b1;
                end
            end else begin
                check_value("o_start", 32'(o_start), 32'd0);
                check_value("o_end", 32'(o_end), 32'd0);
            end
            if (cyc > FRAME_TIMEOUT) begin
                report_failure("frame did not finish before the timeout");
            end
        end
        // sequencer is back in idle with the last point
        check_value("o_ready", 32'(o_ready), 32'd1);
        i_valid = 1'b0;
        i_start = 1'b0;
    endtask

    initial begin
        i_rst_n = 1'b0;
        i_valid = 1'b0;
        i_start = 1'b0;
        i_pixel = 8'h00;
        load_expected();
        repeat (RESET_CYCLES) @(negedge i_clk);
        i_rst_n = 1'b1;
        check_idle(8);
        run_frame(1'b0);
        // restart at once with stalls from the gap pattern
        run_frame(1'b1);
        check_idle(8);
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

/* fast_stimulus.txt */
// 12 image rows of 16 hex pixels, then 16 gap flags (1 = hold i_valid low)
// then the corner count, then one "x y score" line per corner
40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40
40 C8 40 40 40 40 40 40 40 40 40 40 40 40 0A 40
40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40
40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40
40 40 40 40 63 40 40 40 40 40 40 40 40 40 40 40
40 40 40 40 40 40 40 40 40 63 63 63 63 63 63 63
40 40 40 40 40 40 40 40 40 63 63 63 63 63 63 63
40 40 40 40 40 40 40 40 40 63 63 63 63 63 63 63
40 40 40 40 40 1E 40 40 40 63 63 63 63 63 63 63
40 40 40 40 40 40 40 40 40 63 63 63 63 63 63 63
40 40 40 40 40 40 40 40 40 63 63 63 63 63 63 63
40 40 40 40 40 40 40 40 40 63 63 63 63 63 63 63
00 01 00 00 01 01 00 00 00 01 00 00 00 00 01 00
08
04 04 F0
09 05 A5
0A 05 96
0B 05 87
09 06 96
0A 06 87
09 07 87
05 08 E0

/* build.f */
fast_pkg.sv
line_window.sv
frame_sequencer.sv
fast9_segment_test.sv
keypoint_output.sv
fast_detector_top.sv
tb_fast_detector.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fast_detector
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
SOURCES   := $(shell cat $(FILELIST))
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the stimulus file is opened relative to the project root
run: $(SIM_BIN) fast_stimulus.txt
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
